/* gb_dma_subsystem.f */
gb_oam_dma_pkg.sv
gb_oam_dma.sv
gb_mmu.sv
gb_work_ram.sv
gb_oam.sv
gb_dma_subsystem.sv
tb_clock.sv
tb_dma_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dma_subsystem \
  -f gb_dma_subsystem.f -o sim_tb \
  && sim_out="$(./obj_dir/sim_tb)" \
  || { echo "build or simulation run failed"; exit 1; }

echo "$sim_out"

echo "$sim_out" | grep -q "^TEST PASSED$" && exit 0 || exit 1

/* tb_dma_subsystem.sv */
`timescale 1ns/10ps

module tb_dma_subsystem;

  // ========================================
  // limits and dut
  // ========================================

  // reset 3, cpu path ~90, full 960, lockout ~670, restart ~1160, unmapped ~800
  localparam int timeout_cycles = 4000;
  localparam int dma_cycles = 640;

  logic clk;
  logic reset;
  gb_oam_dma_pkg::mem_req_t cpu_req;
  gb_oam_dma_pkg::byte_t cpu_rdata;
  logic dma_active;

  int cycle_count = 0;
  int start_cycle = 0;
  int error_count = 0;
  int check_count = 0;
  logic [31:0] lcg_state = 32'h2974_eb7e;

  // reference copies of both memories
  gb_oam_dma_pkg::byte_t wram_model [gb_oam_dma_pkg::wram_size];
  gb_oam_dma_pkg::byte_t oam_model [gb_oam_dma_pkg::oam_size];

  tb_clock u_clock (
    .clk (clk)
  );

  gb_dma_subsystem UUT (
    .clk        (clk),
    .reset      (reset),
    .cpu_req    (cpu_req),
    .cpu_rdata  (cpu_rdata),
    .dma_active (dma_active)
  );

  // free running cycle count, also the watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ========================================
  // helpers
  // ========================================

  function automatic gb_oam_dma_pkg::byte_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
    end
  endtask

  // every bus task starts and ends 10 ns after a rising edge
  task automatic cpu_write(input gb_oam_dma_pkg::addr_t addr, input gb_oam_dma_pkg::byte_t data);
    cpu_req.addr = addr;
    cpu_req.wdata = data;
    cpu_req.read_en = 1'b0;
    cpu_req.write_en = 1'b1;
    @(posedge clk);
    #10;
    cpu_req = '0;
  endtask

  // read is combinational, sampled mid cycle
  task automatic cpu_read(input gb_oam_dma_pkg::addr_t addr, output gb_oam_dma_pkg::byte_t data);
    cpu_req.addr = addr;
    cpu_req.wdata = 8'h00;
    cpu_req.read_en = 1'b1;
    cpu_req.write_en = 1'b0;
    #40;
    data = cpu_rdata;
    @(posedge clk);
    #10;
    cpu_req = '0;
  endtask

  task automatic write_wram(input int offset, input gb_oam_dma_pkg::byte_t data);
    cpu_write(gb_oam_dma_pkg::wram_base + 16'(offset), data);
    wram_model[offset] = data;
  endtask

  task automatic fill_wram_page(input gb_oam_dma_pkg::byte_t page);
    int base_offset;
    base_offset = int'({page, 8'h00}) - int'(gb_oam_dma_pkg::wram_base);
    for (int i = 0; i < gb_oam_dma_pkg::oam_size; i++) begin
      write_wram(base_offset + i, next_random());
    end
  endtask

  // expected oam after a copy from page xx00
  task automatic model_dma(input gb_oam_dma_pkg::byte_t page);
    int src;
    for (int i = 0; i < gb_oam_dma_pkg::oam_size; i++) begin
      src = int'(page) * 256 + i;
      if (src >= int'(gb_oam_dma_pkg::wram_base) &&
          src < int'(gb_oam_dma_pkg::wram_base) + gb_oam_dma_pkg::wram_size) begin
        oam_model[i] = wram_model[src - int'(gb_oam_dma_pkg::wram_base)];
      end else begin
        oam_model[i] = gb_oam_dma_pkg::open_bus;
      end
    end
  endtask

  task automatic start_dma(input string test_name, input gb_oam_dma_pkg::byte_t page);
    cpu_write(gb_oam_dma_pkg::dma_reg_addr, page);
    start_cycle = cycle_count;
    check_value({test_name, " active after start"}, 1, dma_active);
  endtask

  // edges from the start write until dma_active is seen low
  task automatic wait_dma_done(input string test_name);
    while (dma_active) begin
      @(posedge clk);
      #10;
    end
    check_value({test_name, " active cycles"}, dma_cycles, cycle_count - start_cycle);
  endtask

  task automatic verify_oam(input string test_name);
    gb_oam_dma_pkg::byte_t data;
    for (int i = 0; i < gb_oam_dma_pkg::oam_size; i++) begin
      cpu_read(gb_oam_dma_pkg::oam_base + 16'(i), data);
      check_value($sformatf("%s oam[%0d]", test_name, i), oam_model[i], data);
    end
  endtask

  // ========================================
  // directed tests
  // ========================================

  task automatic test_cpu_path();
    gb_oam_dma_pkg::byte_t data;
    int offsets[$];
    int idx;
    cpu_read(gb_oam_dma_pkg::dma_reg_addr, data);
    check_value("cpu_path dma reg after reset", 8'h00, data);
    // low bytes, then a few scattered over the whole ram
    for (int i = 0; i < 16; i++) begin
      offsets.push_back(i);
    end
    for (int i = 0; i < 8; i++) begin
      offsets.push_back({next_random(), next_random()} % gb_oam_dma_pkg::wram_size);
    end
    foreach (offsets[k]) begin
      write_wram(offsets[k], next_random());
    end
    foreach (offsets[k]) begin
      cpu_read(gb_oam_dma_pkg::wram_base + 16'(offsets[k]), data);
      check_value($sformatf("cpu_path wram[%0h]", offsets[k]), wram_model[offsets[k]], data);
    end
    for (int i = 0; i < 8; i++) begin
      idx = i * 20 + 3;
      oam_model[idx] = next_random();
      cpu_write(gb_oam_dma_pkg::oam_base + 16'(idx), oam_model[idx]);
    end
    for (int i = 0; i < 8; i++) begin
      idx = i * 20 + 3;
      cpu_read(gb_oam_dma_pkg::oam_base + 16'(idx), data);
      check_value($sformatf("cpu_path oam[%0d]", idx), oam_model[idx], data);
    end
    // vram, just past oam, next io register
    cpu_read(16'h8000, data);
    check_value("cpu_path unmapped 8000", gb_oam_dma_pkg::open_bus, data);
    cpu_read(16'hFEA0, data);
    check_value("cpu_path unmapped FEA0", gb_oam_dma_pkg::open_bus, data);
    cpu_read(16'hFF47, data);
    check_value("cpu_path unmapped FF47", gb_oam_dma_pkg::open_bus, data);
  endtask

  task automatic test_full_transfer();
    gb_oam_dma_pkg::byte_t data;
    fill_wram_page(8'hC1);
    start_dma("full", 8'hC1);
    wait_dma_done("full");
    model_dma(8'hC1);
    verify_oam("full");
    cpu_read(gb_oam_dma_pkg::dma_reg_addr, data);
    check_value("full dma reg", 8'hC1, data);
  endtask

  task automatic test_lockout();
    gb_oam_dma_pkg::byte_t data;
    gb_oam_dma_pkg::byte_t held;
    held = wram_model[5];
    start_dma("lockout", 8'hC1);
    // one read per dma phase, so the engine's own read cycle is covered
    for (int i = 0; i < 4; i++) begin
      cpu_read(16'hC105, data);
      check_value("lockout wram read", gb_oam_dma_pkg::open_bus, data);
    end
    for (int i = 0; i < 4; i++) begin
      cpu_read(gb_oam_dma_pkg::oam_base + 16'h0010, data);
      check_value("lockout oam read", gb_oam_dma_pkg::open_bus, data);
    end
    cpu_read(gb_oam_dma_pkg::dma_reg_addr, data);
    check_value("lockout dma reg", 8'hC1, data);
    // this write must be dropped
    cpu_write(gb_oam_dma_pkg::wram_base + 16'h0005, ~held);
    check_value("lockout still active", 1, dma_active);
    wait_dma_done("lockout");
    cpu_read(gb_oam_dma_pkg::wram_base + 16'h0005, data);
    check_value("lockout dropped write", held, data);
  endtask

  task automatic test_restart();
    fill_wram_page(8'hC3);
    start_dma("restart", 8'hC2);
    while (cycle_count - start_cycle < 200) begin
      @(posedge clk);
      #10;
    end
    check_value("restart active before rewrite", 1, dma_active);
    start_dma("restart", 8'hC3);
    wait_dma_done("restart");
    model_dma(8'hC3);
    verify_oam("restart");
  endtask

  task automatic test_unmapped_source();
    start_dma("unmapped_src", 8'h40);
    wait_dma_done("unmapped_src");
    model_dma(8'h40);
    verify_oam("unmapped_src");
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    reset = 1'b1;
    cpu_req = '0;
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;
    test_cpu_path();
    test_full_transfer();
    test_lockout();
    test_restart();
    test_unmapped_source();
    $display("run complete: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  // starts low, first rising edge at 50 ns
  initial begin
    clk = 1'b0;
  end

  // 100 ns period
  always begin
    #50 clk = ~clk;
  end

endmodule

/* gb_dma_subsystem.sv */
`timescale 1ns/10ps

module gb_dma_subsystem (
  input  logic                     clk,
  input  logic                     reset,
  input  gb_oam_dma_pkg::mem_req_t cpu_req,
  output gb_oam_dma_pkg::byte_t    cpu_rdata,
  output logic                     dma_active
);

  // engine <-> mmu
  gb_oam_dma_pkg::mem_req_t reg_req;
  gb_oam_dma_pkg::byte_t reg_rdata;
  gb_oam_dma_pkg::mem_req_t dma_req;
  gb_oam_dma_pkg::byte_t dma_rdata;

  // mmu <-> work ram
  logic [12:0] wram_addr;
  gb_oam_dma_pkg::byte_t wram_wdata;
  logic wram_we;
  gb_oam_dma_pkg::byte_t wram_rdata;

  // mmu <-> oam
  gb_oam_dma_pkg::oam_index_t oam_addr;
  gb_oam_dma_pkg::byte_t oam_wdata;
  logic oam_we;
  gb_oam_dma_pkg::byte_t oam_rdata;

  // ========================================
  // blocks
  // ========================================

  gb_oam_dma u_dma (
    .clk        (clk),
    .reset      (reset),
    .reg_req    (reg_req),
    .reg_rdata  (reg_rdata),
    .dma_req    (dma_req),
    .dma_rdata  (dma_rdata),
    .dma_active (dma_active)
  );

  gb_mmu u_mmu (
    .clk        (clk),
    .reset      (reset),
    .cpu_req    (cpu_req),
    .cpu_rdata  (cpu_rdata),
    .reg_req    (reg_req),
    .reg_rdata  (reg_rdata),
    .dma_req    (dma_req),
    .dma_rdata  (dma_rdata),
    .dma_active (dma_active),
    .wram_addr  (wram_addr),
    .wram_wdata (wram_wdata),
    .wram_we    (wram_we),
    .wram_rdata (wram_rdata),
    .oam_addr   (oam_addr),
    .oam_wdata  (oam_wdata),
    .oam_we     (oam_we),
    .oam_rdata  (oam_rdata)
  );

  gb_work_ram u_wram (
    .clk   (clk),
    .addr  (wram_addr),
    .wdata (wram_wdata),
    .we    (wram_we),
    .rdata (wram_rdata)
  );

  gb_oam u_oam (
    .clk   (clk),
    .addr  (oam_addr),
    .wdata (oam_wdata),
    .we    (oam_we),
    .rdata (oam_rdata)
  );

endmodule

/* gb_oam.sv */
`timescale 1ns/10ps

module gb_oam (
  input  logic                       clk,
  input  gb_oam_dma_pkg::oam_index_t addr,
  input  gb_oam_dma_pkg::byte_t      wdata,
  input  logic                       we,
  output gb_oam_dma_pkg::byte_t      rdata
);

  // 40 sprites x 4 bytes
  gb_oam_dma_pkg::byte_t mem [gb_oam_dma_pkg::oam_size];

  logic in_range;

  // index is 8 bits wide but only 160 slots exist
  assign in_range = addr < gb_oam_dma_pkg::oam_index_t'(gb_oam_dma_pkg::oam_size);

  // ========================================
  // write and read
  // ========================================

  always_ff @(posedge clk) begin
    if (we && in_range) begin
      mem[addr] <= wdata;
    end
  end

  // slots past the end float high
  assign rdata = in_range ? mem[addr] : gb_oam_dma_pkg::open_bus;

endmodule

/* gb_work_ram.sv */
`timescale 1ns/10ps

module gb_work_ram (
  input  logic                  clk,
  input  logic [12:0]           addr,
  input  gb_oam_dma_pkg::byte_t wdata,
  input  logic                  we,
  output gb_oam_dma_pkg::byte_t rdata
);

  // ========================================
  // storage
  // ========================================

  // 8 KiB, C000..DFFF seen from the cpu
  gb_oam_dma_pkg::byte_t mem [gb_oam_dma_pkg::wram_size];

  // write lands on the edge that samples we
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // asynchronous read, same cycle as the address
  assign rdata = mem[addr];

endmodule

/* gb_mmu.sv */
`timescale 1ns/10ps

module gb_mmu (
  input  logic                       clk,
  input  logic                       reset,
  // cpu master
  input  gb_oam_dma_pkg::mem_req_t   cpu_req,
  output gb_oam_dma_pkg::byte_t      cpu_rdata,
  // dma register access
  output gb_oam_dma_pkg::mem_req_t   reg_req,
  input  gb_oam_dma_pkg::byte_t      reg_rdata,
  // dma master
  input  gb_oam_dma_pkg::mem_req_t   dma_req,
  output gb_oam_dma_pkg::byte_t      dma_rdata,
  input  logic                       dma_active,
  // work ram port
  output logic [12:0]                wram_addr,
  output gb_oam_dma_pkg::byte_t      wram_wdata,
  output logic                       wram_we,
  input  gb_oam_dma_pkg::byte_t      wram_rdata,
  // oam port
  output gb_oam_dma_pkg::oam_index_t oam_addr,
  output gb_oam_dma_pkg::byte_t      oam_wdata,
  output logic                       oam_we,
  input  gb_oam_dma_pkg::byte_t      oam_rdata
);

  // request that owns the memories this cycle
  gb_oam_dma_pkg::mem_req_t mem_req;
  // offsets from each region base
  gb_oam_dma_pkg::addr_t wram_off;
  gb_oam_dma_pkg::addr_t oam_off;
  logic wram_hit;
  logic oam_hit;
  gb_oam_dma_pkg::byte_t mem_rdata;

  // ========================================
  // arbitration
  // ========================================

  // register stays reachable by the cpu, dma or not
  assign reg_req = cpu_req;

  // dma owns the memories while active, cpu is locked out
  assign mem_req = dma_active ? dma_req : cpu_req;

  // ========================================
  // address decode
  // ========================================

  // wraps below base, so one compare per region
  assign wram_off = mem_req.addr - gb_oam_dma_pkg::wram_base;
  assign oam_off = mem_req.addr - gb_oam_dma_pkg::oam_base;
  assign wram_hit = wram_off < gb_oam_dma_pkg::addr_t'(gb_oam_dma_pkg::wram_size);
  assign oam_hit = oam_off < gb_oam_dma_pkg::addr_t'(gb_oam_dma_pkg::oam_size);

  assign wram_addr = wram_off[12:0];
  assign wram_wdata = mem_req.wdata;
  assign wram_we = mem_req.write_en && wram_hit;

  assign oam_addr = oam_off[7:0];
  assign oam_wdata = mem_req.wdata;
  assign oam_we = mem_req.write_en && oam_hit;

  // ========================================
  // read data
  // ========================================

  always_comb begin
    mem_rdata = gb_oam_dma_pkg::open_bus;
    if (mem_req.read_en) begin
      if (wram_hit) begin
        mem_rdata = wram_rdata;
      end else if (oam_hit) begin
        mem_rdata = oam_rdata;
      end
    end
  end

  // unmapped dma source reads as open bus too
  assign dma_rdata = dma_active ? mem_rdata : gb_oam_dma_pkg::open_bus;

  always_comb begin
    cpu_rdata = gb_oam_dma_pkg::open_bus;
    if (cpu_req.addr == gb_oam_dma_pkg::dma_reg_addr) begin
      cpu_rdata = reg_rdata;
    end else if (!dma_active) begin
      cpu_rdata = mem_rdata;
    end
  end

  // engine only writes oam, so no work ram write at all during dma
  assert property (@(posedge clk) disable iff (reset)
    dma_active |-> !wram_we)
    else $error("work ram written during dma");

endmodule

/* gb_oam_dma.sv */
`timescale 1ns/10ps

module gb_oam_dma (
  input  logic                     clk,
  input  logic                     reset,
  // cpu side, register access
  input  gb_oam_dma_pkg::mem_req_t reg_req,
  output gb_oam_dma_pkg::byte_t    reg_rdata,
  // memory side, bus master while active
  output gb_oam_dma_pkg::mem_req_t dma_req,
  input  gb_oam_dma_pkg::byte_t    dma_rdata,
  output logic                     dma_active
);

  // source page, high byte of every read address
  gb_oam_dma_pkg::byte_t dma_page;
  // byte being copied
  gb_oam_dma_pkg::oam_index_t dma_index;
  gb_oam_dma_pkg::dma_phase_t phase;

  // registered bus strobes
  logic req_read_en;
  logic req_write_en;
  // registered bus payload
  gb_oam_dma_pkg::addr_t req_addr;
  gb_oam_dma_pkg::byte_t req_wdata;

  logic reg_selected;
  logic reg_write;
  logic last_byte;
  gb_oam_dma_pkg::addr_t read_addr;
  gb_oam_dma_pkg::addr_t write_addr;

  // ========================================
  // decode and addressing
  // ========================================

  assign reg_selected = reg_req.addr == gb_oam_dma_pkg::dma_reg_addr;
  assign reg_write = reg_selected && reg_req.write_en;

  // source xx00+i, destination FE00+i
  assign read_addr = {dma_page, dma_index};
  assign write_addr = {gb_oam_dma_pkg::oam_base[15:8], dma_index};

  assign last_byte = dma_index == gb_oam_dma_pkg::oam_index_t'(gb_oam_dma_pkg::oam_size - 1);

  // ========================================
  // control
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dma_page <= '0;
      dma_index <= '0;
      dma_active <= 1'b0;
      phase <= gb_oam_dma_pkg::t1;
      req_read_en <= 1'b0;
      req_write_en <= 1'b0;
    end else if (reg_write) begin
      // start, or restart from byte 0 when already running
      dma_page <= reg_req.wdata;
      dma_index <= '0;
      dma_active <= 1'b1;
      phase <= gb_oam_dma_pkg::t1;
      req_read_en <= 1'b0;
      req_write_en <= 1'b0;
    end else if (dma_active) begin
      unique case (phase)
        gb_oam_dma_pkg::t1: begin
          // source address goes out with read strobe
          req_read_en <= 1'b1;
          phase <= gb_oam_dma_pkg::t2;
        end
        gb_oam_dma_pkg::t2: begin
          // read data valid now, switch over to the oam write
          req_read_en <= 1'b0;
          req_write_en <= 1'b1;
          phase <= gb_oam_dma_pkg::t3;
        end
        gb_oam_dma_pkg::t3: begin
          phase <= gb_oam_dma_pkg::t4;
        end
        gb_oam_dma_pkg::t4: begin
          req_write_en <= 1'b0;
          phase <= gb_oam_dma_pkg::t1;
          if (last_byte) begin
            // byte 159 written, hand the bus back
            dma_active <= 1'b0;
            dma_index <= '0;
          end else begin
            dma_index <= dma_index + 8'd1;
          end
        end
      endcase
    end
  end

  // address and write data follow the phase
  always_ff @(posedge clk) begin
    if (dma_active && !reg_write) begin
      if (phase == gb_oam_dma_pkg::t1) begin
        req_addr <= read_addr;
      end else if (phase == gb_oam_dma_pkg::t2) begin
        req_addr <= write_addr;
        req_wdata <= dma_rdata;
      end
    end
  end

  assign dma_req = '{
    addr: req_addr,
    wdata: req_wdata,
    read_en: req_read_en,
    write_en: req_write_en
  };

  // register readback, open bus otherwise
  assign reg_rdata = (reg_selected && reg_req.read_en) ? dma_page : gb_oam_dma_pkg::open_bus;

  // ========================================
  // checks
  // ========================================

  // one transfer direction per cycle
  assert property (@(posedge clk) disable iff (reset)
    !(dma_req.read_en && dma_req.write_en))
    else $error("dma read and write strobes high together");

  // index stays inside oam across the whole transfer
  assert property (@(posedge clk) disable iff (reset)
    dma_index < gb_oam_dma_pkg::oam_index_t'(gb_oam_dma_pkg::oam_size))
    else $error("dma index out of oam range");

endmodule

/* gb_oam_dma_pkg.sv */
package gb_oam_dma_pkg;

  // ========================================
  // basic widths
  // ========================================

  // one byte on the data bus
  typedef logic [7:0] byte_t;

  // full 16 bit cpu address
  typedef logic [15:0] addr_t;

  // oam slot, only 0..159 are valid
  typedef logic [7:0] oam_index_t;

  // ========================================
  // memory map
  // ========================================

  // dma source page register
  localparam addr_t dma_reg_addr = 16'hFF46;

  // object attribute memory, FE00..FE9F
  localparam addr_t oam_base = 16'hFE00;
  localparam int oam_size = 160;

  // work ram, C000..DFFF
  localparam addr_t wram_base = 16'hC000;
  localparam int wram_size = 8192;

  // value seen on unmapped or locked reads
  localparam byte_t open_bus = 8'hFF;

  // ========================================
  // dma engine and bus types
  // ========================================

  // four cycles per copied byte
  typedef enum logic [1:0] {
    t1,  // drive source address, read
    t2,  // latch read data, start oam write
    t3,  // write in progress
    t4   // write done, next byte
  } dma_phase_t;

  // request of one bus master, 26 bits
  typedef struct packed {
    addr_t addr;
    byte_t wdata;
    logic  read_en;
    logic  write_en;
  } mem_req_t;

endpackage
